// File: common/spi_pkg.sv
package spi_pkg;

	// ----------------------------------------
	// frame layout on the wire, msb first
	// ----------------------------------------

	// field widths
	localparam int SPI_OPCODE_BITS = 8;
	localparam int SPI_ADDRESS_BITS = 16;
	localparam int SPI_DATA_BITS = 32;

	// whole frame, and the command+address part
	localparam int SPI_FRAME_BITS = 56;
	localparam int SPI_HEADER_BITS = 24;

	// word_clock cycles from address phase to readback capture
	localparam int SPI_READ_SETTLE = 4;

	// counter widths inside the slave
	// bit counter saturates well above a full frame
	localparam int SPI_COUNT_BITS = 7;
	localparam int SPI_SETTLE_BITS = 3;

	// ----------------------------------------
	// command byte
	// ----------------------------------------
	typedef enum logic [SPI_OPCODE_BITS-1:0] {
		OP_NOP   = 8'h00,
		OP_WRITE = 8'h01,
		OP_READ  = 8'h02
	} spi_opcode_t;

	// one full transaction, fields in wire order
	typedef struct packed {
		spi_opcode_t                 opcode;
		logic [SPI_ADDRESS_BITS-1:0] address;
		logic [SPI_DATA_BITS-1:0]    data;
	} spi_transaction_t;

endpackage

// File: common/wavegen_pkg.sv
package wavegen_pkg;

	// ----------------------------------------
	// register map (chip select 0)
	// ----------------------------------------
	localparam int REG_ADDR_BITS = 4;
	localparam int REG_DATA_BITS = 32;

	// playback window, in stream bytes
	localparam int REG_START = 0;
	localparam int REG_END = 1;
	// bit 0 enables playback
	localparam int REG_CONTROL = 2;
	localparam int CONTROL_ENABLE_BIT = 0;

	// 12..14 read as zero, 15 is the sweep counter
	localparam int REG_FIRST_ZERO = 12;
	localparam int REG_STATUS = 15;

	// ----------------------------------------
	// waveform memory (chip select 1)
	// ----------------------------------------
	localparam int WORD_ADDR_BITS = 12;
	localparam int MEMORY_WORDS = 4096;
	// four bytes per word
	localparam int BYTE_ADDR_BITS = 14;
	localparam int SAMPLE_BITS = 8;

	// ----------------------------------------
	// playback
	// ----------------------------------------

	// end_byte is exclusive
	typedef struct packed {
		logic [BYTE_ADDR_BITS-1:0] start_byte;
		logic [BYTE_ADDR_BITS-1:0] end_byte;
		logic                      enable;
	} playback_window_t;

	// sync marks the sample of start_byte
	typedef struct packed {
		logic [SAMPLE_BITS-1:0] value;
		logic                   sync;
	} sample_t;

endpackage

// File: spi/spi_command_slave.sv
module spi_command_slave (
	input  logic                                 word_clock,
	input  logic                                 reset4_word_clock,
	input  logic                                 sclk,
	input  logic                                 mosi,
	input  logic                                 ce_n,
	input  logic [spi_pkg::SPI_DATA_BITS-1:0]    read_data,
	output logic                                 miso,
	output logic                                 address_strobe,
	output logic [spi_pkg::SPI_ADDRESS_BITS-1:0] address,
	output logic                                 write_strobe,
	output spi_pkg::spi_transaction_t            transaction
);
	import spi_pkg::*;

	// synchronizers, third bit of sclk/ce is the edge history
	logic [2:0] sclk_pipe;
	logic [1:0] mosi_pipe;
	logic [2:0] ce_pipe;
	logic sclk_rise;
	logic sclk_fall;
	logic ce_high;
	logic ce_rise;
	logic mosi_bit;

	// frame capture
	logic [SPI_FRAME_BITS-1:0] shift_in;
	logic [SPI_COUNT_BITS-1:0] bit_count;
	spi_transaction_t frame;
	logic header_done;

	// readback
	logic [SPI_SETTLE_BITS-1:0] settle_count;
	logic [SPI_DATA_BITS-1:0] shift_out;

	// ----------------------------------------
	// input synchronizers and edge finding
	// ----------------------------------------
	always_ff @(posedge word_clock) begin
		if (reset4_word_clock) begin
			sclk_pipe <= '0;
			mosi_pipe <= '0;
			// deselected
			ce_pipe <= '1;
		end else begin
			sclk_pipe <= {sclk_pipe[1:0], sclk};
			mosi_pipe <= {mosi_pipe[0], mosi};
			ce_pipe <= {ce_pipe[1:0], ce_n};
		end
	end

	assign sclk_rise = sclk_pipe[1] & ~sclk_pipe[2];
	assign sclk_fall = ~sclk_pipe[1] & sclk_pipe[2];
	assign ce_high = ce_pipe[1];
	assign ce_rise = ce_pipe[1] & ~ce_pipe[2];
	assign mosi_bit = mosi_pipe[1];

	// view of the shift register as fields
	assign frame = spi_transaction_t'(shift_in);
	assign header_done = bit_count >= SPI_HEADER_BITS;

	// ----------------------------------------
	// bit counting and strobes
	// ----------------------------------------
	always_ff @(posedge word_clock) begin
		if (reset4_word_clock) begin
			bit_count <= '0;
			address_strobe <= 1'b0;
			write_strobe <= 1'b0;
		end else begin
			address_strobe <= 1'b0;
			write_strobe <= 1'b0;
			// only a complete write frame commits
			if (ce_rise && bit_count == SPI_FRAME_BITS && frame.opcode == OP_WRITE) begin
				write_strobe <= 1'b1;
			end
			if (ce_high) begin
				bit_count <= '0;
			end else if (sclk_rise) begin
				// saturate so long frames stay invalid
				if (bit_count != '1) begin
					bit_count <= bit_count + 1'b1;
				end
				if (bit_count == SPI_HEADER_BITS - 1) begin
					address_strobe <= 1'b1;
				end
			end
		end
	end

	// shift in msb first, latch address after bit 24
	always_ff @(posedge word_clock) begin
		if (sclk_rise && !ce_high) begin
			shift_in <= {shift_in[SPI_FRAME_BITS-2:0], mosi_bit};
			if (bit_count == SPI_HEADER_BITS - 1) begin
				address <= {shift_in[SPI_ADDRESS_BITS-2:0], mosi_bit};
			end
		end
		// qualified by write_strobe
		if (ce_rise) begin
			transaction <= frame;
		end
	end

	// ----------------------------------------
	// readback path
	// ----------------------------------------
	always_ff @(posedge word_clock) begin
		if (reset4_word_clock) begin
			settle_count <= '0;
			miso <= 1'b0;
		end else begin
			// give the target time to present read_data
			if (address_strobe) begin
				settle_count <= SPI_SETTLE_BITS'(SPI_READ_SETTLE);
			end else if (settle_count != '0) begin
				settle_count <= settle_count - 1'b1;
			end
			// miso changes after sck falls, data phase only
			if (ce_high) begin
				miso <= 1'b0;
			end else if (sclk_fall && header_done) begin
				miso <= shift_out[SPI_DATA_BITS-1];
			end
		end
	end

	always_ff @(posedge word_clock) begin
		if (settle_count == 1) begin
			shift_out <= read_data;
		end else if (sclk_fall && header_done && !ce_high) begin
			shift_out <= {shift_out[SPI_DATA_BITS-2:0], 1'b0};
		end
	end

	// commit only after the host has released chip select
	write_only_when_deselected: assert property (
		@(posedge word_clock) disable iff (reset4_word_clock)
		write_strobe |-> ce_n
	);

endmodule

// File: logic/control_registers.sv
module control_registers (
	input  logic                                 word_clock,
	input  logic                                 reset4_word_clock,
	input  logic                                 write_strobe,
	input  spi_pkg::spi_transaction_t            transaction,
	input  logic [wavegen_pkg::REG_ADDR_BITS-1:0] read_address,
	input  logic [wavegen_pkg::REG_DATA_BITS-1:0] sweep_count,
	output logic [wavegen_pkg::REG_DATA_BITS-1:0] read_data,
	output wavegen_pkg::playback_window_t        window
);
	import wavegen_pkg::*;

	// only 0..11 have storage
	logic [REG_DATA_BITS-1:0] regs [REG_FIRST_ZERO];
	logic [REG_ADDR_BITS-1:0] write_index;

	// low address bits pick the register
	assign write_index = transaction.address[REG_ADDR_BITS-1:0];

	// ----------------------------------------
	// host writes
	// ----------------------------------------
	always_ff @(posedge word_clock) begin
		if (reset4_word_clock) begin
			regs <= '{default: '0};
		end else if (write_strobe && write_index < REG_FIRST_ZERO) begin
			// writes to 12..15 just fall away
			regs[write_index] <= transaction.data;
		end
	end

	// ----------------------------------------
	// host reads, one cycle
	// ----------------------------------------
	always_ff @(posedge word_clock) begin
		if (read_address == REG_STATUS) begin
			read_data <= sweep_count;
		end else if (read_address >= REG_FIRST_ZERO) begin
			read_data <= '0;
		end else begin
			read_data <= regs[read_address];
		end
	end

	// playback window straight from the registers
	// sequencer latches it at each wrap
	assign window = '{
		start_byte: regs[REG_START][BYTE_ADDR_BITS-1:0],
		end_byte:   regs[REG_END][BYTE_ADDR_BITS-1:0],
		enable:     regs[REG_CONTROL][CONTROL_ENABLE_BIT]
	};

endmodule

// File: logic/waveform_memory.sv
module waveform_memory (
	input  logic                                  word_clock,
	input  logic                                  reset4_word_clock,
	input  logic                                  write_enable,
	input  logic [wavegen_pkg::WORD_ADDR_BITS-1:0] word_address,
	input  logic [wavegen_pkg::REG_DATA_BITS-1:0]  write_word,
	input  logic [wavegen_pkg::BYTE_ADDR_BITS-1:0] byte_address,
	output logic [wavegen_pkg::REG_DATA_BITS-1:0]  read_word,
	output logic [wavegen_pkg::SAMPLE_BITS-1:0]    sample_value
);
	import wavegen_pkg::*;

	// stored with stream byte 4w+k in lane k
	logic [REG_DATA_BITS-1:0] ram [MEMORY_WORDS];

	logic [WORD_ADDR_BITS-1:0] byte_word;
	logic [BYTE_ADDR_BITS-WORD_ADDR_BITS-1:0] byte_lane;

	// first byte on the wire is the top byte of the host word
	function automatic logic [REG_DATA_BITS-1:0] swap_bytes(
		input logic [REG_DATA_BITS-1:0] word
	);
		return {word[7:0], word[15:8], word[23:16], word[31:24]};
	endfunction

	// ----------------------------------------
	// port a, host side
	// ----------------------------------------
	always_ff @(posedge word_clock) begin
		if (write_enable) begin
			ram[word_address] <= swap_bytes(write_word);
		end
		// swap back so the host sees what it wrote
		read_word <= swap_bytes(ram[word_address]);
	end

	// ----------------------------------------
	// port b, byte stream for playback
	// ----------------------------------------
	assign byte_word = byte_address[BYTE_ADDR_BITS-1:BYTE_ADDR_BITS-WORD_ADDR_BITS];
	assign byte_lane = byte_address[BYTE_ADDR_BITS-WORD_ADDR_BITS-1:0];

	always_ff @(posedge word_clock) begin
		sample_value <= ram[byte_word][byte_lane*SAMPLE_BITS +: SAMPLE_BITS];
	end

	// address comes from the slave's latched header
	write_address_known: assert property (
		@(posedge word_clock) disable iff (reset4_word_clock)
		write_enable |-> !$isunknown(word_address)
	);

endmodule

// File: logic/playback_sequencer.sv
module playback_sequencer (
	input  logic                                   word_clock,
	input  logic                                   reset4_word_clock,
	input  wavegen_pkg::playback_window_t          window,
	input  logic [wavegen_pkg::SAMPLE_BITS-1:0]    sample_value,
	output logic [wavegen_pkg::BYTE_ADDR_BITS-1:0] byte_address,
	output wavegen_pkg::sample_t                   sample,
	output logic [wavegen_pkg::REG_DATA_BITS-1:0]  sweep_count
);
	import wavegen_pkg::*;

	// window in force for the current sweep
	playback_window_t latched;
	// high while start_byte is being issued
	logic sync_issue;
	// lined up with the memory output
	logic sync_delayed;
	logic last_byte;

	// end_byte is exclusive
	assign last_byte = byte_address == latched.end_byte - 1'b1;

	// ----------------------------------------
	// address sweep, reload only at wrap
	// ----------------------------------------
	always_ff @(posedge word_clock) begin
		if (reset4_word_clock) begin
			latched <= '0;
			byte_address <= '0;
			sync_issue <= 1'b0;
			sync_delayed <= 1'b0;
			sweep_count <= '0;
		end else begin
			sync_delayed <= sync_issue;
			if (!latched.enable) begin
				// idle: track the registers, park at start
				latched <= window;
				byte_address <= window.start_byte;
				sync_issue <= window.enable;
			end else if (last_byte) begin
				// wrap, pick up any new window
				latched <= window;
				byte_address <= window.start_byte;
				sync_issue <= window.enable;
				sweep_count <= sweep_count + 1'b1;
			end else begin
				byte_address <= byte_address + 1'b1;
				sync_issue <= 1'b0;
			end
		end
	end

	// memory port b adds one cycle, sync follows it
	assign sample = '{value: sample_value, sync: sync_delayed};

	// skip degenerate windows where end is not above start
	address_inside_window: assert property (
		@(posedge word_clock) disable iff (reset4_word_clock)
		(latched.enable && latched.start_byte < latched.end_byte)
			|-> (byte_address >= latched.start_byte && byte_address < latched.end_byte)
	);

endmodule

// File: logic/wavegen_top.sv
module wavegen_top (
	input  logic                 word_clock,
	input  logic                 reset4_word_clock,
	input  logic                 spi_sclk,
	input  logic                 spi_mosi,
	input  logic                 spi_ce0,
	input  logic                 spi_ce1,
	output logic                 spi_miso,
	output wavegen_pkg::sample_t sample,
	output logic                 sweep_active
);
	import spi_pkg::*;
	import wavegen_pkg::*;

	// register side (ce0)
	logic register_miso;
	logic [SPI_ADDRESS_BITS-1:0] register_address;
	logic register_write_strobe;
	spi_transaction_t register_transaction;
	logic [REG_DATA_BITS-1:0] register_read_data;

	// memory side (ce1)
	logic memory_miso;
	logic [SPI_ADDRESS_BITS-1:0] memory_address;
	logic memory_write_strobe;
	spi_transaction_t memory_transaction;
	logic [REG_DATA_BITS-1:0] memory_read_data;
	logic [WORD_ADDR_BITS-1:0] memory_word_address;

	// playback
	playback_window_t window;
	logic [REG_DATA_BITS-1:0] sweep_count;
	logic [BYTE_ADDR_BITS-1:0] byte_address;
	logic [SAMPLE_BITS-1:0] sample_value;

	// ----------------------------------------
	// spi slaves on the shared bus
	// ----------------------------------------
	spi_command_slave register_spi (
		.word_clock(word_clock), .reset4_word_clock(reset4_word_clock),
		.sclk(spi_sclk), .mosi(spi_mosi), .ce_n(spi_ce0), .read_data(register_read_data),
		.miso(register_miso), .address_strobe(), .address(register_address),
		.write_strobe(register_write_strobe), .transaction(register_transaction)
	);

	spi_command_slave memory_spi (
		.word_clock(word_clock), .reset4_word_clock(reset4_word_clock),
		.sclk(spi_sclk), .mosi(spi_mosi), .ce_n(spi_ce1), .read_data(memory_read_data),
		.miso(memory_miso), .address_strobe(), .address(memory_address),
		.write_strobe(memory_write_strobe), .transaction(memory_transaction)
	);

	// only the selected slave talks, idle low
	assign spi_miso = !spi_ce0 ? register_miso : (!spi_ce1 ? memory_miso : 1'b0);

	// ----------------------------------------
	// targets and playback
	// ----------------------------------------
	control_registers registers (
		.word_clock(word_clock), .reset4_word_clock(reset4_word_clock),
		.write_strobe(register_write_strobe), .transaction(register_transaction),
		.read_address(register_address[REG_ADDR_BITS-1:0]), .sweep_count(sweep_count),
		.read_data(register_read_data), .window(window)
	);

	// write uses the committed frame, reads the live header
	assign memory_word_address = memory_write_strobe ?
		memory_transaction.address[WORD_ADDR_BITS-1:0] : memory_address[WORD_ADDR_BITS-1:0];

	waveform_memory memory (
		.word_clock(word_clock), .reset4_word_clock(reset4_word_clock),
		.write_enable(memory_write_strobe), .word_address(memory_word_address),
		.write_word(memory_transaction.data), .byte_address(byte_address),
		.read_word(memory_read_data), .sample_value(sample_value)
	);

	playback_sequencer sequencer (
		.word_clock(word_clock), .reset4_word_clock(reset4_word_clock),
		.window(window), .sample_value(sample_value),
		.byte_address(byte_address), .sample(sample), .sweep_count(sweep_count)
	);

	assign sweep_active = window.enable;

endmodule

// File: tests/tb_wavegen.sv
module tb_wavegen;
	timeunit 1ns;
	timeprecision 100ps;
	import spi_pkg::*;
	import wavegen_pkg::*;

	// sck half-period in word_clock cycles
	localparam int HALF_PERIOD = 10;
	localparam int SYNC_TIMEOUT = 200;
	// words loaded for playback
	localparam int MODEL_WORDS = 8;

	// one stimulus row
	// bits below 56 make a truncated frame
	typedef struct packed {
		logic        cs;
		spi_opcode_t opcode;
		logic [15:0] address;
		logic [31:0] data;
		logic [31:0] expected;
		int          bits;
	} table_row_t;

	logic word_clock;
	logic reset4_word_clock;
	logic spi_sclk;
	logic spi_mosi;
	logic spi_ce0;
	logic spi_ce1;
	logic spi_miso;
	sample_t sample;
	logic sweep_active;

	table_row_t rows[$];
	// host view of memory words 0..7
	logic [31:0] mem_model [MODEL_WORDS];
	integer seed = 32'h5a78_86c5;

	wavegen_top UUT (
		.word_clock(word_clock), .reset4_word_clock(reset4_word_clock),
		.spi_sclk(spi_sclk), .spi_mosi(spi_mosi), .spi_ce0(spi_ce0), .spi_ce1(spi_ce1),
		.spi_miso(spi_miso), .sample(sample), .sweep_active(sweep_active)
	);

	initial begin
		word_clock = 1'b0;
		forever #2 word_clock = ~word_clock;
	end

	// ----------------------------------------
	// timing and checks
	// ----------------------------------------

	// drive and sample 1 ns after the edge
	task automatic step();
		@(posedge word_clock);
		#1;
	endtask

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Simulation FAILED");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_word(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		if (got !== expected)
			abort_run($sformatf("[FAIL] %0t %s got %h expected %h", $time, name, got, expected));
	endtask

	task automatic check_bit(input string name, input logic got, input logic expected);
		if (got !== expected)
			abort_run($sformatf("[FAIL] %0t %s got %b expected %b", $time, name, got, expected));
	endtask

	task automatic check_sample(input sample_t got, input sample_t expected);
		if (got !== expected)
			abort_run($sformatf("[FAIL] %0t sample got %h/%b expected %h/%b", $time,
				got.value, got.sync, expected.value, expected.sync));
	endtask

	// ----------------------------------------
	// spi master
	// ----------------------------------------

	// sends msb first and leaves chip select low
	task automatic spi_frame(input logic cs, input spi_transaction_t tr, input int bits,
		output logic [31:0] readback);
		logic [SPI_FRAME_BITS-1:0] frame_bits;
		int i;
		frame_bits = tr;
		readback = '0;
		if (cs) spi_ce1 = 1'b0;
		else spi_ce0 = 1'b0;
		repeat (HALF_PERIOD) step();
		for (i = 0; i < bits; i++) begin
			spi_mosi = frame_bits[SPI_FRAME_BITS-1-i];
			repeat (HALF_PERIOD) step();
			// miso settled since the last falling edge
			if (i >= SPI_HEADER_BITS) readback = {readback[30:0], spi_miso};
			spi_sclk = 1'b1;
			repeat (HALF_PERIOD) step();
			spi_sclk = 0;
		end
		repeat (HALF_PERIOD) step();
	endtask

	// deselect and leave time for the commit
	task automatic release_cs();
		spi_ce0 = 1'b1;
		spi_ce1 = 1'b1;
		repeat (12) step();
	endtask

	task automatic write_register(input int address, input logic [31:0] data);
		spi_transaction_t tr;
		logic [31:0] readback;
		tr = '{opcode: OP_WRITE, address: 16'(address), data: data};
		spi_frame(1'b0, tr, SPI_FRAME_BITS, readback);
		release_cs();
	endtask

	task automatic read_register(input int address, output logic [31:0] data);
		spi_transaction_t tr;
		tr = '{opcode: OP_READ, address: 16'(address), data: 32'd0};
		spi_frame(1'b0, tr, SPI_FRAME_BITS, data);
		release_cs();
	endtask

	// ----------------------------------------
	// playback model
	// ----------------------------------------

	// first byte on the wire is stream byte 4w+0
	function automatic logic [7:0] stream_byte(input int b);
		logic [31:0] word;
		word = mem_model[b / 4];
		return word[31 - 8 * (b % 4) -: 8];
	endfunction

	task automatic wait_sync();
		int waited;
		waited = 0;
		while (sample.sync !== 1'b1) begin
			if (waited == SYNC_TIMEOUT) abort_run("no sync pulse seen before the timeout");
			step();
			waited++;
		end
	endtask

	// offset counts from the sync sample of the window
	task automatic check_stream(input int start_byte, input int end_byte, input int offset,
		input int count);
		sample_t expected;
		int index;
		int k;
		for (k = 0; k < count; k++) begin
			index = (offset + k) % (end_byte - start_byte);
			expected.value = stream_byte(start_byte + index);
			expected.sync = (index == 0);
			check_sample(sample, expected);
			step();
		end
	endtask

	// ----------------------------------------
	// stimulus table
	// ----------------------------------------
	task automatic add_row(input logic cs, input spi_opcode_t opcode, input int address,
		input logic [31:0] data, input logic [31:0] expected, input int bits);
		table_row_t row;
		row = '{cs, opcode, 16'(address), data, expected, bits};
		rows.push_back(row);
	endtask

	task automatic build_table();
		logic [31:0] reg_value [4];
		int r;
		// control reads zero out of reset
		add_row(0, OP_READ, REG_CONTROL, 32'd0, 32'd0, 56);
		// keep the enable bit clear here
		for (r = 0; r < 4; r++) begin
			reg_value[r] = $random(seed);
			if (r == REG_CONTROL) reg_value[r][CONTROL_ENABLE_BIT] = 1'b0;
			add_row(0, OP_WRITE, r, reg_value[r], 32'd0, 56);
		end
		for (r = 0; r < 4; r++) add_row(0, OP_READ, r, 32'd0, reg_value[r], 56);
		// 12..14 swallow writes
		for (r = 12; r < 15; r++) begin
			add_row(0, OP_WRITE, r, $random(seed), 32'd0, 56);
			add_row(0, OP_READ, r, 32'd0, 32'd0, 56);
		end
		for (r = 0; r < MODEL_WORDS; r++) begin
			mem_model[r] = $random(seed);
			add_row(1, OP_WRITE, r, mem_model[r], 32'd0, 56);
		end
		for (r = 0; r < MODEL_WORDS; r++) add_row(1, OP_READ, r, 32'd0, mem_model[r], 56);
		// read, nop and short write all leave word 3 alone
		add_row(1, OP_READ, 3, $random(seed), mem_model[3], 56);
		add_row(1, OP_WRITE, 3, $random(seed), 32'd0, 55);
		add_row(1, OP_NOP, 3, $random(seed), 32'd0, 56);
		add_row(1, OP_READ, 3, 32'd0, mem_model[3], 56);
	endtask

	initial begin
		spi_transaction_t tr;
		logic [31:0] readback;
		logic [31:0] status_first;
		logic [31:0] status_second;
		spi_sclk = 1'b0;
		spi_mosi = 1'b0;
		spi_ce0 = 1'b1;
		spi_ce1 = 1'b1;
		reset4_word_clock = 1'b1;
		repeat (4) @(posedge word_clock);
		#1 reset4_word_clock = 1'b0;
		// quiet after reset
		repeat (8) begin
			check_bit("sample.sync", sample.sync, 1'b0);
			check_bit("sweep_active", sweep_active, 1'b0);
			check_bit("spi_miso", spi_miso, 1'b0);
			step();
		end
		build_table();
		foreach (rows[i]) begin
			tr = '{opcode: rows[i].opcode, address: rows[i].address, data: rows[i].data};
			spi_frame(rows[i].cs, tr, rows[i].bits, readback);
			release_cs();
			if (rows[i].opcode == OP_READ)
				check_word($sformatf("readback cs%0d addr %0d", rows[i].cs, rows[i].address),
					readback, rows[i].expected);
		end
		// two sweeps of window 5..23
		write_register(REG_START, 32'd5);
		write_register(REG_END, 32'd23);
		write_register(REG_CONTROL, 32'd1);
		check_bit("sweep_active", sweep_active, 1'b1);
		wait_sync();
		check_stream(5, 23, 0, 36);
		// new end committed a few samples into a sweep
		tr = '{opcode: OP_WRITE, address: 16'(REG_END), data: 32'd20};
		spi_frame(1'b0, tr, SPI_FRAME_BITS, readback);
		wait_sync();
		check_stream(5, 23, 0, 4);
		spi_ce0 = 1'b1;
		check_stream(5, 23, 4, 14);
		check_stream(5, 20, 0, 30);
		// disable and let the current sweep drain
		write_register(REG_CONTROL, 32'd0);
		repeat (15) step();
		repeat (45) begin
			check_bit("sample.sync", sample.sync, 1'b0);
			step();
		end
		check_bit("sweep_active", sweep_active, 1'b0);
		// sweep count frozen while idle
		read_register(REG_STATUS, status_first);
		read_register(REG_STATUS, status_second);
		check_word("status repeat read", status_second, status_first);
		check_bit("status nonzero", status_first != 32'd0, 1'b1);
		$display("Simulation PASSED");
		$finish;
	end

endmodule

// File: flist.f
common/spi_pkg.sv
common/wavegen_pkg.sv
spi/spi_command_slave.sv
logic/control_registers.sv
logic/waveform_memory.sv
logic/playback_sequencer.sv
logic/wavegen_top.sv
tests/tb_wavegen.sv
